/* logic/esfaBench_config.svh */
`ifndef ESFA_BENCH_CONFIG_SVH
`define ESFA_BENCH_CONFIG_SVH

// Number of elements held by the ESFA store
`define ESFA_DEPTH 16

// Program memory words, one run can visit each once
`define PROG_DEPTH 64

`define APB_ADDR_WIDTH 8

`endif

/* logic/esfaPkg.sv */
package esfaPkg;

  //////////////////////////////////////////////////
  // Store data types
  //////////////////////////////////////////////////

  // Element index, only the low bits select within the store
  typedef logic [7:0] esfaIndexT;

  // Value held by one element
  typedef logic [7:0] esfaValueT;

  // Compare value kept in the metadata register
  typedef logic [7:0] esfaMetaT;

endpackage

/* logic/benchPkg.sv */
package benchPkg;

  //////////////////////////////////////////////////
  // Program and run types
  //////////////////////////////////////////////////

  // Flags in bits 3..0, then newIndex, newValue, metadata, selector
  typedef logic [39:0] programWordT;

  typedef logic [5:0] programAddrT;

  typedef logic [31:0] cycleCountT;

  typedef enum logic {
    stateIdle,
    stateRunning
  } benchStateT;

  //////////////////////////////////////////////////
  // APB register map
  //////////////////////////////////////////////////

  typedef logic [7:0] regOffsetT;

  localparam regOffsetT offCtrl      = 8'h00;
  localparam regOffsetT offStatus    = 8'h04;
  localparam regOffsetT offCycles    = 8'h08;
  localparam regOffsetT offProgAddr  = 8'h0C;
  localparam regOffsetT offProgLo    = 8'h10;
  localparam regOffsetT offProgHi    = 8'h14;
  localparam regOffsetT offLastValue = 8'h18;

endpackage

/* logic/esfaStore.sv */
`timescale 1ns/100ps

`include "esfaBench_config.svh"

module esfaStore (
  input  logic              clk,
  input  logic              reset,
  input  logic              storeClear,
  input  logic              storeWrite,
  input  logic              isMetadata,
  input  esfaPkg::esfaIndexT newIndex,
  input  esfaPkg::esfaValueT newValue,
  input  esfaPkg::esfaMetaT  metadata,
  input  esfaPkg::esfaIndexT selector,
  output logic              resultBool,
  output esfaPkg::esfaValueT resultValue
);

  localparam int IndexBits = $clog2(`ESFA_DEPTH);

  esfaPkg::esfaValueT elements [`ESFA_DEPTH];
  esfaPkg::esfaMetaT  metaReg;

  logic [IndexBits-1:0] writeSlot;
  logic [IndexBits-1:0] readSlot;

  // Indices wrap modulo the store depth
  assign writeSlot = newIndex[IndexBits-1:0];
  assign readSlot  = selector[IndexBits-1:0];

  //////////////////////////////////////////////////
  // Mutations
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!reset || storeClear) begin
      metaReg <= '0;
      for (int i = 0; i < `ESFA_DEPTH; i++) begin
        elements[i] <= '0;
      end
    end else if (storeWrite) begin
      if (isMetadata) begin
        metaReg <= metadata;
      end else begin
        elements[writeSlot] <= newValue;
      end
    end
  end

  //////////////////////////////////////////////////
  // Query
  //////////////////////////////////////////////////

  assign resultValue = elements[readSlot];

  // Selected element matches the metadata register
  assign resultBool = (resultValue == metaReg);

endmodule

/* logic/programMemory.sv */
`timescale 1ns/100ps

`include "esfaBench_config.svh"

module programMemory (
  input  logic                  clk,
  input  logic                  progWrite,
  input  benchPkg::programAddrT progWAddr,
  input  benchPkg::programWordT progWData,
  input  benchPkg::programAddrT progRAddr,
  output benchPkg::programWordT progRData
);

  // Contents only come from APB loading
  benchPkg::programWordT words [`PROG_DEPTH];

  always_ff @(posedge clk) begin
    if (progWrite) begin
      words[progWAddr] <= progWData;
    end
  end

  // Sequencer sees the word in the same cycle
  assign progRData = words[progRAddr];

endmodule

/* logic/benchSequencer.sv */
`timescale 1ns/100ps

module benchSequencer (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  doRun,
  output benchPkg::programAddrT progRAddr,
  input  benchPkg::programWordT progRData,
  output logic                  storeClear,
  output logic                  storeWrite,
  output logic                  isMetadata,
  output esfaPkg::esfaIndexT    newIndex,
  output esfaPkg::esfaValueT    newValue,
  output esfaPkg::esfaMetaT     metadata,
  output esfaPkg::esfaIndexT    selector,
  input  logic                  resultBool,
  input  esfaPkg::esfaValueT    resultValue,
  output logic                  isRunning,
  output logic                  wasSuccessful,
  output logic                  done,
  output benchPkg::cycleCountT  cycleCount,
  output esfaPkg::esfaValueT    lastValue
);

  benchPkg::benchStateT  state;
  benchPkg::programAddrT addr;

  logic isMutating;
  logic expectedResultBool;
  logic endOfProgram;
  logic executeWord;
  logic mismatch;
  logic lastAddr;

  //////////////////////////////////////////////////
  // Word decode
  //////////////////////////////////////////////////

  assign isMutating         = progRData[0];
  assign expectedResultBool = progRData[1];
  assign endOfProgram       = progRData[2];
  assign isMetadata         = progRData[3];
  assign newIndex           = progRData[15:8];
  assign newValue           = progRData[23:16];
  assign metadata           = progRData[31:24];
  assign selector           = progRData[39:32];

  assign isRunning   = (state == benchPkg::stateRunning);
  // End word is never executed
  assign executeWord = isRunning && !endOfProgram;
  assign mismatch    = executeWord && !isMutating && (resultBool != expectedResultBool);
  assign lastAddr    = (addr == '1);

  // Store is emptied on the same edge the run starts
  assign storeClear = (state == benchPkg::stateIdle) && doRun;
  assign storeWrite = executeWord && isMutating;
  assign progRAddr  = addr;

  //////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!reset) begin
      state         <= benchPkg::stateIdle;
      addr          <= '0;
      cycleCount    <= '0;
      wasSuccessful <= 1'b1;
      done          <= 1'b0;
      lastValue     <= '0;
    end else begin
      case (state)
        benchPkg::stateIdle: begin
          if (doRun) begin
            state         <= benchPkg::stateRunning;
            addr          <= '0;
            cycleCount    <= '0;
            wasSuccessful <= 1'b1;
            done          <= 1'b0;
          end
        end
        benchPkg::stateRunning: begin
          if (endOfProgram) begin
            state <= benchPkg::stateIdle;
            done  <= 1'b1;
          end else begin
            addr       <= addr + 1'b1;
            cycleCount <= cycleCount + 1'b1;
            if (!isMutating) begin
              lastValue <= resultValue;
            end
            // Failing word still counts
            if (mismatch) begin
              wasSuccessful <= 1'b0;
              state         <= benchPkg::stateIdle;
              done          <= 1'b1;
            end else if (lastAddr) begin
              state <= benchPkg::stateIdle;
              done  <= 1'b1;
            end
          end
        end
        default: state <= benchPkg::stateIdle;
      endcase
    end
  end

endmodule

/* logic/benchApbRegs.sv */
`timescale 1ns/100ps

`include "esfaBench_config.svh"

module benchApbRegs (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       pSel,
  input  logic                       pEnable,
  input  logic                       pWrite,
  input  logic [`APB_ADDR_WIDTH-1:0] pAddr,
  input  logic [31:0]                pWData,
  output logic [31:0]                pRData,
  output logic                       pReady,
  output logic                       pSlvErr,
  output logic                       doRun,
  output logic                       progWrite,
  output benchPkg::programAddrT      progWAddr,
  output benchPkg::programWordT      progWData,
  input  logic                       isRunning,
  input  logic                       wasSuccessful,
  input  logic                       done,
  input  benchPkg::cycleCountT       cycleCount,
  input  esfaPkg::esfaValueT         lastValue
);

  benchPkg::regOffsetT   offset;
  benchPkg::programAddrT loadAddr;
  logic [31:0]           progLo;

  logic access;
  logic isMapped;
  logic isReadOnly;
  logic isProgReg;
  logic writeOk;

  //////////////////////////////////////////////////
  // Decode and error rules
  //////////////////////////////////////////////////

  assign offset = benchPkg::regOffsetT'(pAddr);
  assign access = pSel && pEnable;

  always_comb begin
    isMapped   = 1'b1;
    isReadOnly = 1'b0;
    isProgReg  = 1'b0;
    case (offset)
      benchPkg::offCtrl: ;
      benchPkg::offStatus,
      benchPkg::offCycles,
      benchPkg::offLastValue: isReadOnly = 1'b1;
      benchPkg::offProgAddr,
      benchPkg::offProgLo,
      benchPkg::offProgHi: isProgReg = 1'b1;
      default: isMapped = 1'b0;
    endcase
  end

  // No wait states
  assign pReady = 1'b1;

  assign pSlvErr = access && (!isMapped ||
                              (pWrite && isReadOnly) ||
                              (pWrite && isProgReg && isRunning));

  assign writeOk = access && pWrite && !pSlvErr;

  //////////////////////////////////////////////////
  // Control and loading
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!reset) begin
      doRun     <= 1'b0;
      progWrite <= 1'b0;
      loadAddr  <= '0;
    end else begin
      doRun     <= writeOk && (offset == benchPkg::offCtrl) && pWData[0];
      progWrite <= writeOk && (offset == benchPkg::offProgHi);
      if (writeOk && (offset == benchPkg::offProgAddr)) begin
        loadAddr <= benchPkg::programAddrT'(pWData);
      end else if (writeOk && (offset == benchPkg::offProgHi)) begin
        // Auto increment for back to back loading
        if (loadAddr == benchPkg::programAddrT'(`PROG_DEPTH - 1)) begin
          loadAddr <= '0;
        end else begin
          loadAddr <= loadAddr + 1'b1;
        end
      end
    end
  end

  // Staged word and write address
  always_ff @(posedge clk) begin
    if (writeOk && (offset == benchPkg::offProgLo)) begin
      progLo <= pWData;
    end
    if (writeOk && (offset == benchPkg::offProgHi)) begin
      progWAddr <= loadAddr;
      progWData <= {pWData[7:0], progLo};
    end
  end

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////

  always_comb begin
    pRData = '0;
    case (offset)
      benchPkg::offStatus:    pRData = {29'd0, done, wasSuccessful, isRunning};
      benchPkg::offCycles:    pRData = cycleCount;
      benchPkg::offProgAddr:  pRData = {26'd0, loadAddr};
      benchPkg::offProgLo:    pRData = progLo;
      benchPkg::offProgHi:    pRData = {24'd0, progWData[39:32]};
      benchPkg::offLastValue: pRData = {24'd0, lastValue};
      default:                pRData = '0;
    endcase
  end

endmodule

/* logic/esfaBenchTop.sv */
`timescale 1ns/100ps

`include "esfaBench_config.svh"

module esfaBenchTop (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       pSel,
  input  logic                       pEnable,
  input  logic                       pWrite,
  input  logic [`APB_ADDR_WIDTH-1:0] pAddr,
  input  logic [31:0]                pWData,
  output logic [31:0]                pRData,
  output logic                       pReady,
  output logic                       pSlvErr
);

  logic                  doRun;
  logic                  progWrite;
  benchPkg::programAddrT progWAddr;
  benchPkg::programWordT progWData;
  benchPkg::programAddrT progRAddr;
  benchPkg::programWordT progRData;

  logic                 storeClear;
  logic                 storeWrite;
  logic                 isMetadata;
  esfaPkg::esfaIndexT   newIndex;
  esfaPkg::esfaValueT   newValue;
  esfaPkg::esfaMetaT    metadata;
  esfaPkg::esfaIndexT   selector;
  logic                 resultBool;
  esfaPkg::esfaValueT   resultValue;

  logic                 isRunning;
  logic                 wasSuccessful;
  logic                 done;
  benchPkg::cycleCountT cycleCount;
  esfaPkg::esfaValueT   lastValue;

  benchApbRegs i_apbRegs (
    .clk, .reset,
    .pSel, .pEnable, .pWrite, .pAddr, .pWData, .pRData, .pReady, .pSlvErr,
    .doRun, .progWrite, .progWAddr, .progWData,
    .isRunning, .wasSuccessful, .done, .cycleCount, .lastValue
  );

  programMemory i_programMemory (
    .clk, .progWrite, .progWAddr, .progWData, .progRAddr, .progRData
  );

  benchSequencer i_sequencer (
    .clk, .reset, .doRun, .progRAddr, .progRData,
    .storeClear, .storeWrite, .isMetadata, .newIndex, .newValue, .metadata, .selector,
    .resultBool, .resultValue,
    .isRunning, .wasSuccessful, .done, .cycleCount, .lastValue
  );

  esfaStore i_store (
    .clk, .reset, .storeClear, .storeWrite, .isMetadata,
    .newIndex, .newValue, .metadata, .selector, .resultBool, .resultValue
  );

endmodule

/* test/esfaBenchTb.sv */
`timescale 1ns/100ps

`include "esfaBench_config.svh"

module esfaBenchTb;

  localparam int NumTests = 5;

  logic                       clk;
  logic                       reset;
  logic                       pSel;
  logic                       pEnable;
  logic                       pWrite;
  logic [`APB_ADDR_WIDTH-1:0] pAddr;
  logic [31:0]                pWData;
  logic [31:0]                pRData;
  logic                       pReady;
  logic                       pSlvErr;

  integer      seed = 32'h76d2;
  int          errorCount;
  int          checkCount;
  int          cycleCounter;
  int          cycleLimit;
  logic [31:0] rdata;
  logic        slvErr;

  // Program words, each test owns a slice
  benchPkg::programWordT wordTable [128];
  int                    wordCount;
  int                    testCount;
  string                 testName  [NumTests];
  int                    testStart [NumTests];
  int                    testLen   [NumTests];
  bit                    testPoke  [NumTests];
  bit                    expOk     [NumTests];
  int                    expCycles [NumTests];
  logic [7:0]            expLast   [NumTests];

  // Reference store
  logic [7:0] modelElems [`ESFA_DEPTH];
  logic [7:0] modelMeta;
  logic [7:0] modelLast;

  esfaBenchTop i_dut (
    .clk, .reset,
    .pSel, .pEnable, .pWrite, .pAddr, .pWData, .pRData, .pReady, .pSlvErr
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycleCounter++;
    if (cycleCounter >= cycleLimit) begin
      $display("timeout after %0d cycles, the run did not finish", cycleCounter);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // APB access, called right after a falling edge
  //////////////////////////////////////////////////

  task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, output logic err);
    pSel    = 1'b1;
    pEnable = 1'b0;
    pWrite  = 1'b1;
    pAddr   = addr;
    pWData  = data;
    @(negedge clk);
    pEnable = 1'b1;
    #1;
    err = pSlvErr;
    checkEqual("pReady", 32'h1, pReady);
    @(negedge clk);
    pSel    = 1'b0;
    pEnable = 1'b0;
    pWrite  = 1'b0;
  endtask

  task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
    pSel    = 1'b1;
    pEnable = 1'b0;
    pWrite  = 1'b0;
    pAddr   = addr;
    @(negedge clk);
    pEnable = 1'b1;
    #1;
    data = pRData;
    err  = pSlvErr;
    checkEqual("pReady", 32'h1, pReady);
    @(negedge clk);
    pSel    = 1'b0;
    pEnable = 1'b0;
  endtask

  task automatic checkEqual(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("error %s expected %h actual %h", name, expected, actual);
    end
  endtask

  //////////////////////////////////////////////////
  // Program word builders
  //////////////////////////////////////////////////

  function automatic benchPkg::programWordT elemWord(input logic [7:0] idx, input logic [7:0] val);
    return {8'h00, 8'h00, val, idx, 8'h01};
  endfunction

  function automatic benchPkg::programWordT metaWord(input logic [7:0] meta);
    return {8'h00, meta, 8'h00, 8'h00, 8'h09};
  endfunction

  // Expected flag sits in bit 1
  function automatic benchPkg::programWordT checkWord(input logic [7:0] sel, input logic expFlag);
    return {sel, 24'h0, 6'b0, expFlag, 1'b0};
  endfunction

  function automatic benchPkg::programWordT endWord();
    return {32'h0, 8'h04};
  endfunction

  task automatic addWord(input benchPkg::programWordT w);
    wordTable[wordCount] = w;
    wordCount++;
  endtask

  task automatic addTest(input string name, input int start, input bit poke);
    testName[testCount]  = name;
    testStart[testCount] = start;
    testLen[testCount]   = wordCount - start;
    testPoke[testCount]  = poke;
    testCount++;
  endtask

  task automatic buildTable();
    logic [31:0] r;
    logic [7:0]  v0;
    logic [7:0]  v1;
    int          start;
    wordCount = 0;
    testCount = 0;
    r  = $random(seed);
    v0 = r[7:0];
    r  = $random(seed);
    v1 = r[7:0];
    start = wordCount;
    addWord(elemWord(8'd3, v0));
    addWord(elemWord(8'd7, v1));
    addWord(metaWord(v0));
    addWord(checkWord(8'd3, 1'b1));
    addWord(metaWord(v1));
    addWord(checkWord(8'd7, 1'b1));
    addWord(endWord());
    addTest("elemChecks", start, 1'b0);
    // Checks that expect false where values differ
    start = wordCount;
    addWord(elemWord(8'd1, 8'h5A));
    addWord(elemWord(8'd2, 8'hA5));
    addWord(metaWord(8'h5A));
    addWord(checkWord(8'd1, 1'b1));
    addWord(checkWord(8'd2, 1'b0));
    addWord(checkWord(8'd9, 1'b0));
    addWord(endWord());
    addTest("metaFalse", start, 1'b0);
    // Fourth word carries the wrong flag
    start = wordCount;
    addWord(elemWord(8'd4, 8'h33));
    addWord(metaWord(8'h33));
    addWord(checkWord(8'd4, 1'b1));
    addWord(checkWord(8'd4, 1'b0));
    addWord(checkWord(8'd4, 1'b1));
    addWord(endWord());
    addTest("wrongFlag", start, 1'b0);
    // Element 4 and metadata were set by the run before
    start = wordCount;
    addWord(checkWord(8'd4, 1'b1));
    addWord(checkWord(8'd1, 1'b1));
    addWord(endWord());
    addTest("freshStore", start, 1'b0);
    // Full memory, no end word, slot 3 reached through wrapped indices
    start = wordCount;
    addWord(elemWord(8'h13, v1));
    addWord(metaWord(v1));
    addWord(checkWord(8'h23, 1'b1));
    for (int i = 0; i < `PROG_DEPTH - 4; i++) begin
      r = $random(seed);
      addWord(elemWord({r[7:4], 1'b1, r[2:0]}, r[15:8]));
    end
    addWord(checkWord(8'hE3, 1'b1));
    addTest("wrapIndex", start, 1'b1);
  endtask

  //////////////////////////////////////////////////
  // Expected results from the store rule
  //////////////////////////////////////////////////

  task automatic runModel(input int t);
    benchPkg::programWordT w;
    logic [7:0]            value;
    expOk[t]     = 1'b1;
    expCycles[t] = 0;
    modelMeta    = '0;
    foreach (modelElems[i]) begin
      modelElems[i] = '0;
    end
    for (int a = 0; a < testLen[t]; a++) begin
      w = wordTable[testStart[t] + a];
      if (w[2]) begin
        break;
      end
      expCycles[t]++;
      if (w[0]) begin
        if (w[3]) begin
          modelMeta = w[31:24];
        end else begin
          modelElems[w[15:8] % `ESFA_DEPTH] = w[23:16];
        end
      end else begin
        value     = modelElems[w[39:32] % `ESFA_DEPTH];
        modelLast = value;
        if ((value == modelMeta) != w[1]) begin
          expOk[t] = 1'b0;
          break;
        end
      end
    end
    expLast[t] = modelLast;
  endtask

  task automatic runTest(input int t);
    logic [31:0] data;
    logic        err;
    apbWrite(benchPkg::offProgAddr, 32'h0, err);
    for (int i = 0; i < testLen[t]; i++) begin
      apbWrite(benchPkg::offProgLo, wordTable[testStart[t] + i][31:0], err);
      apbWrite(benchPkg::offProgHi, {24'h0, wordTable[testStart[t] + i][39:32]}, err);
    end
    apbWrite(benchPkg::offCtrl, 32'h1, err);
    if (testPoke[t]) begin
      apbWrite(benchPkg::offProgLo, 32'h0, err);
      checkEqual({testName[t], " progLo slvErr"}, 32'h1, err);
      apbWrite(benchPkg::offProgAddr, 32'h5, err);
      checkEqual({testName[t], " progAddr slvErr"}, 32'h1, err);
      // Second start while busy is accepted on the bus but has no effect
      apbWrite(benchPkg::offCtrl, 32'h1, err);
      checkEqual({testName[t], " ctrl slvErr"}, 32'h0, err);
      // Six words executed since the start edge
      // A restart on the second start would read zero here
      apbRead(benchPkg::offCycles, data, err);
      checkEqual({testName[t], " busyCycles"}, 32'd6, data);
    end
    data = '0;
    while (!data[2]) begin
      apbRead(benchPkg::offStatus, data, err);
    end
    checkEqual({testName[t], " status"}, {29'd0, 1'b1, expOk[t], 1'b0}, data);
    apbRead(benchPkg::offCycles, data, err);
    checkEqual({testName[t], " cycles"}, expCycles[t], data);
    apbRead(benchPkg::offLastValue, data, err);
    checkEqual({testName[t], " lastValue"}, {24'd0, expLast[t]}, data);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    reset   = 1'b0;
    pSel    = 1'b0;
    pEnable = 1'b0;
    pWrite  = 1'b0;
    pAddr   = '0;
    pWData  = '0;
    buildTable();
    cycleLimit = 200 + 8 * wordCount;
    modelLast  = '0;
    for (int t = 0; t < testCount; t++) begin
      runModel(t);
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b1;

    apbRead(benchPkg::offStatus, rdata, slvErr);
    checkEqual("resetStatus", 32'h2, rdata);
    apbRead(benchPkg::offCycles, rdata, slvErr);
    checkEqual("resetCycles", 32'h0, rdata);

    // Bus errors while idle
    apbRead(8'h1C, rdata, slvErr);
    checkEqual("unmappedRead slvErr", 32'h1, slvErr);
    apbWrite(8'h40, 32'h1, slvErr);
    checkEqual("unmappedWrite slvErr", 32'h1, slvErr);
    apbWrite(benchPkg::offStatus, 32'h0, slvErr);
    checkEqual("statusWrite slvErr", 32'h1, slvErr);
    apbRead(benchPkg::offStatus, rdata, slvErr);
    checkEqual("statusRead slvErr", 32'h0, slvErr);

    for (int t = 0; t < testCount; t++) begin
      runTest(t);
    end

    $display("checks %0d errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* esfaBench.f */
+incdir+logic
logic/esfaPkg.sv
logic/benchPkg.sv
logic/esfaStore.sv
logic/programMemory.sv
logic/benchSequencer.sv
logic/benchApbRegs.sv
logic/esfaBenchTop.sv
test/esfaBenchTb.sv

/* Bender.yml */
package:
  name: esfaBench

sources:
  - include_dirs:
      - logic
    files:
      - logic/esfaPkg.sv
      - logic/benchPkg.sv
      - logic/esfaStore.sv
      - logic/programMemory.sv
      - logic/benchSequencer.sv
      - logic/benchApbRegs.sv
      - logic/esfaBenchTop.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/esfaBenchTb.sv
